// ==== include/l2_cache_settings.svh ====
// L2 cache geometry
`ifndef L2_CACHE_SETTINGS_SVH
`define L2_CACHE_SETTINGS_SVH

// Associativity and way index width
`define L2_NUM_WAYS 4
`define L2_WAY_BITS 2

// Sets per way
`define L2_NUM_SETS 8
`define L2_SET_BITS 3

// Line address is the tag above the set index
`define L2_TAG_BITS 3
`define L2_ADDR_BITS 6

// One cache line
`define L2_LINE_BITS 128

// Requester identity fields
`define L2_CORE_BITS 2
`define L2_STRAND_BITS 2
`define L2_UNIT_BITS 2

`endif

// ==== hdl/l2_cache_pkg.sv ====
// L2 cache opcodes

package l2_cache_pkg;

	// Request operations from the cores
	typedef enum logic [2:0]
	{
		L2REQ_LOAD = 3'd0,
		L2REQ_STORE = 3'd1,
		L2REQ_FLUSH = 3'd2,
		L2REQ_INVALIDATE = 3'd3,
		L2REQ_LOAD_SYNC = 3'd4,
		L2REQ_STORE_SYNC = 3'd5
	} l2req_op_t;

	// Response operations back to the cores
	// Sync variants share the plain load and store acks
	typedef enum logic [1:0]
	{
		L2RSP_LOAD_ACK = 2'd0,
		L2RSP_STORE_ACK = 2'd1,
		L2RSP_FLUSH_ACK = 2'd2,
		L2RSP_INVALIDATE_ACK = 2'd3
	} l2rsp_op_t;

endpackage

// ==== hdl/l2_cache_tag.sv ====
// L2 cache tag stage
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_tag(
	input clk,
	input reset,
	input req_valid,
	input [`L2_CORE_BITS-1:0] req_core,
	input [`L2_UNIT_BITS-1:0] req_unit,
	input [`L2_STRAND_BITS-1:0] req_strand,
	input l2_cache_pkg::l2req_op_t req_op,
	input [`L2_ADDR_BITS-1:0] req_address,
	input [`L2_LINE_BITS-1:0] req_data,
	output logic req_ready,
	output logic s1_valid,
	output logic [`L2_CORE_BITS-1:0] s1_core,
	output logic [`L2_UNIT_BITS-1:0] s1_unit,
	output logic [`L2_STRAND_BITS-1:0] s1_strand,
	output l2_cache_pkg::l2req_op_t s1_op,
	output logic [`L2_SET_BITS-1:0] s1_set,
	output logic [`L2_TAG_BITS-1:0] s1_tag,
	output logic [`L2_LINE_BITS-1:0] s1_data);

	logic [`L2_SET_BITS-1:0] req_set;
	logic [`L2_TAG_BITS-1:0] req_tag;
	logic accept;

	// Set index in the low bits, tag above it
	assign req_set = req_address[`L2_SET_BITS-1:0];
	assign req_tag = req_address[`L2_ADDR_BITS-1:`L2_SET_BITS];

	// Hold off a request to the set that stage 1 is looking up
	// Its way writes land one cycle later, so this costs one cycle
	assign req_ready = !(s1_valid && s1_set == req_set);
	assign accept = req_valid && req_ready;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= accept;
	end

	// Request payload, only loaded on acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			s1_core <= req_core;
			s1_unit <= req_unit;
			s1_strand <= req_strand;
			s1_op <= req_op;
			s1_set <= req_set;
			s1_tag <= req_tag;
			s1_data <= req_data;
		end
	end

endmodule

// ==== hdl/l2_cache_way.sv ====
// L2 cache way bank
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_way(
	input clk,
	input reset,
	input [`L2_SET_BITS-1:0] lookup_set,
	input [`L2_TAG_BITS-1:0] lookup_tag,
	input write_en,
	input [`L2_SET_BITS-1:0] write_set,
	input [`L2_TAG_BITS-1:0] write_tag,
	input [`L2_LINE_BITS-1:0] write_data,
	input write_valid,
	input write_dirty,
	output logic hit,
	output logic line_valid,
	output logic line_dirty,
	output logic [`L2_TAG_BITS-1:0] line_tag,
	output logic [`L2_LINE_BITS-1:0] line_data);

	// Per set state bits
	logic [`L2_NUM_SETS-1:0] valid_bits;
	logic [`L2_NUM_SETS-1:0] dirty_bits;

	// Tag and line storage
	logic [`L2_TAG_BITS-1:0] tag_mem [`L2_NUM_SETS];
	logic [`L2_LINE_BITS-1:0] data_mem [`L2_NUM_SETS];

	// All lines start invalid and clean
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else if (write_en)
		begin
			valid_bits[write_set] <= write_valid;
			dirty_bits[write_set] <= write_dirty;
		end
	end

	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			tag_mem[write_set] <= write_tag;
			data_mem[write_set] <= write_data;
		end
	end

	// Combinational lookup of the addressed set
	assign line_valid = valid_bits[lookup_set];
	assign line_dirty = dirty_bits[lookup_set];
	assign line_tag = tag_mem[lookup_set];
	assign line_data = data_mem[lookup_set];

	// Hit needs a live line with a matching tag
	assign hit = line_valid && line_tag == lookup_tag;

endmodule

// ==== hdl/l2_cache_read.sv ====
// L2 cache read stage
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_read(
	input clk,
	input reset,
	input s1_valid,
	input [`L2_CORE_BITS-1:0] s1_core,
	input [`L2_UNIT_BITS-1:0] s1_unit,
	input [`L2_STRAND_BITS-1:0] s1_strand,
	input l2_cache_pkg::l2req_op_t s1_op,
	input [`L2_SET_BITS-1:0] s1_set,
	input [`L2_TAG_BITS-1:0] s1_tag,
	input [`L2_LINE_BITS-1:0] s1_data,
	input [`L2_NUM_WAYS-1:0] way_hit,
	input [`L2_NUM_WAYS-1:0] way_valid,
	input [`L2_NUM_WAYS-1:0] way_dirty,
	input [`L2_NUM_WAYS-1:0][`L2_TAG_BITS-1:0] way_tag,
	input [`L2_NUM_WAYS-1:0][`L2_LINE_BITS-1:0] way_data,
	input [`L2_LINE_BITS-1:0] mem_read_data,
	output logic [`L2_NUM_WAYS-1:0] way_write_en,
	output logic [`L2_SET_BITS-1:0] way_write_set,
	output logic [`L2_TAG_BITS-1:0] way_write_tag,
	output logic [`L2_LINE_BITS-1:0] way_write_data,
	output logic way_write_valid,
	output logic way_write_dirty,
	output logic mem_write_en,
	output logic [`L2_ADDR_BITS-1:0] mem_write_address,
	output logic [`L2_LINE_BITS-1:0] mem_write_data,
	output logic s2_valid,
	output logic [`L2_CORE_BITS-1:0] s2_core,
	output logic [`L2_UNIT_BITS-1:0] s2_unit,
	output logic [`L2_STRAND_BITS-1:0] s2_strand,
	output l2_cache_pkg::l2req_op_t s2_op,
	output logic [`L2_WAY_BITS-1:0] s2_way,
	output logic [`L2_LINE_BITS-1:0] s2_data,
	output logic s2_sync_success);

	// One reservation per core and strand
	localparam NUM_RES = 1 << (`L2_CORE_BITS + `L2_STRAND_BITS);

	// Stage 2 copies of the request
	logic [`L2_SET_BITS-1:0] s2_set;
	logic [`L2_TAG_BITS-1:0] s2_tag;
	logic [`L2_LINE_BITS-1:0] s2_req_data;
	logic [`L2_LINE_BITS-1:0] s2_mem_data;

	// Stage 2 copies of the way state
	logic [`L2_NUM_WAYS-1:0] s2_hit;
	logic [`L2_NUM_WAYS-1:0] s2_line_valid;
	logic [`L2_NUM_WAYS-1:0] s2_line_dirty;
	logic [`L2_NUM_WAYS-1:0][`L2_TAG_BITS-1:0] s2_line_tag;
	logic [`L2_NUM_WAYS-1:0][`L2_LINE_BITS-1:0] s2_line_data;

	// Replacement pointers and sync reservations
	logic [`L2_NUM_SETS-1:0][`L2_WAY_BITS-1:0] rr_ptr;
	logic [NUM_RES-1:0] res_valid;
	logic [`L2_ADDR_BITS-1:0] res_address [NUM_RES];

	logic cache_hit;
	logic [`L2_WAY_BITS-1:0] hit_way;
	logic [`L2_WAY_BITS-1:0] victim_way;
	logic fill;
	logic store_write;
	logic write_line;
	logic writeback;
	logic [`L2_LINE_BITS-1:0] old_line;
	logic [`L2_ADDR_BITS-1:0] s2_address;
	logic [`L2_CORE_BITS+`L2_STRAND_BITS-1:0] res_index;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		s2_core <= s1_core;
		s2_unit <= s1_unit;
		s2_strand <= s1_strand;
		s2_op <= s1_op;
		s2_set <= s1_set;
		s2_tag <= s1_tag;
		s2_req_data <= s1_data;
		s2_mem_data <= mem_read_data;
		s2_hit <= way_hit;
		s2_line_valid <= way_valid;
		s2_line_dirty <= way_dirty;
		s2_line_tag <= way_tag;
		s2_line_data <= way_data;
	end

	assign s2_address = {s2_tag, s2_set};
	assign res_index = {s2_core, s2_strand};

	// Hit way, and lowest invalid way else the round robin pick
	always_comb
	begin
		hit_way = '0;
		victim_way = rr_ptr[s2_set];
		for (int i = `L2_NUM_WAYS - 1; i >= 0; i--)
		begin
			if (s2_hit[i])
				hit_way = i[`L2_WAY_BITS-1:0];
			if (!s2_line_valid[i])
				victim_way = i[`L2_WAY_BITS-1:0];
		end
	end

	always_comb
	begin
		cache_hit = |s2_hit;
		s2_way = cache_hit ? hit_way : victim_way;

		// Current line contents, from the way or from memory on a miss
		old_line = cache_hit ? s2_line_data[hit_way] : s2_mem_data;

		// Store-sync only goes through on its own live reservation
		s2_sync_success = s2_op == l2_cache_pkg::L2REQ_STORE_SYNC && res_valid[res_index]
			&& res_address[res_index] == s2_address;
		store_write = s2_op == l2_cache_pkg::L2REQ_STORE || s2_sync_success;

		// Full line stores replace the whole line
		s2_data = store_write ? s2_req_data : old_line;

		fill = 1'b0;
		write_line = 1'b0;
		writeback = 1'b0;
		way_write_valid = 1'b1;
		way_write_dirty = store_write || (cache_hit && s2_line_dirty[hit_way]);
		mem_write_address = s2_address;
		mem_write_data = old_line;

		case (s2_op)
			l2_cache_pkg::L2REQ_FLUSH:
			begin
				// Keep the line but push dirty data out
				write_line = cache_hit;
				way_write_dirty = 1'b0;
				writeback = cache_hit && s2_line_dirty[hit_way];
			end

			l2_cache_pkg::L2REQ_INVALIDATE:
			begin
				// Drop the line after saving dirty data
				write_line = cache_hit;
				way_write_valid = 1'b0;
				way_write_dirty = 1'b0;
				writeback = cache_hit && s2_line_dirty[hit_way];
			end

			default:
			begin
				// Loads and stores allocate on a miss
				fill = !cache_hit;
				write_line = fill || store_write;
				if (fill && s2_line_valid[victim_way] && s2_line_dirty[victim_way])
				begin
					writeback = 1'b1;
					mem_write_address = {s2_line_tag[victim_way], s2_set};
					mem_write_data = s2_line_data[victim_way];
				end
			end
		endcase

		mem_write_en = s2_valid && writeback;
		for (int i = 0; i < `L2_NUM_WAYS; i++)
			way_write_en[i] = s2_valid && write_line && s2_way == i[`L2_WAY_BITS-1:0];
	end

	// Shared write fields for every way
	assign way_write_set = s2_set;
	assign way_write_tag = s2_tag;
	assign way_write_data = s2_data;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rr_ptr <= '0;
			res_valid <= '0;
		end
		else if (s2_valid)
		begin
			if (fill)
				rr_ptr[s2_set] <= rr_ptr[s2_set] + 1'b1;

			// A completed store kills every reservation on its line
			for (int i = 0; i < NUM_RES; i++)
			begin
				if (store_write && res_address[i] == s2_address)
					res_valid[i] <= 1'b0;
			end

			if (s2_op == l2_cache_pkg::L2REQ_LOAD_SYNC)
				res_valid[res_index] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s2_valid && s2_op == l2_cache_pkg::L2REQ_LOAD_SYNC)
			res_address[res_index] <= s2_address;
	end

endmodule

// ==== hdl/l2_system_memory.sv ====
// L2 backing memory
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_system_memory(
	input clk,
	input [`L2_ADDR_BITS-1:0] read_address,
	input write_en,
	input [`L2_ADDR_BITS-1:0] write_address,
	input [`L2_LINE_BITS-1:0] write_data,
	output logic [`L2_LINE_BITS-1:0] read_data);

	localparam MEM_LINES = 1 << `L2_ADDR_BITS;

	// One line per address, cleared at power up
	logic [`L2_LINE_BITS-1:0] mem [MEM_LINES] = '{default: '0};

	always_ff @(posedge clk)
	begin
		if (write_en)
			mem[write_address] <= write_data;
	end

	// Registered read port
	// A write to the same address in the same cycle is passed through,
	// so a line written back two requests earlier is seen fresh
	always_ff @(posedge clk)
	begin
		if (write_en && write_address == read_address)
			read_data <= write_data;
		else
			read_data <= mem[read_address];
	end

endmodule

// ==== hdl/l2_cache_response.sv ====
// L2 cache response stage
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_response(
	input clk,
	input reset,
	input s2_valid,
	input [`L2_CORE_BITS-1:0] s2_core,
	input [`L2_UNIT_BITS-1:0] s2_unit,
	input [`L2_STRAND_BITS-1:0] s2_strand,
	input l2_cache_pkg::l2req_op_t s2_op,
	input [`L2_WAY_BITS-1:0] s2_way,
	input [`L2_LINE_BITS-1:0] s2_data,
	input s2_sync_success,
	output logic rsp_valid,
	output logic rsp_status,
	output logic [`L2_CORE_BITS-1:0] rsp_core,
	output logic [`L2_UNIT_BITS-1:0] rsp_unit,
	output logic [`L2_STRAND_BITS-1:0] rsp_strand,
	output l2_cache_pkg::l2rsp_op_t rsp_op,
	output logic [`L2_WAY_BITS-1:0] rsp_way,
	output logic [`L2_LINE_BITS-1:0] rsp_data);

	l2_cache_pkg::l2rsp_op_t response_op;

	// Request to response opcode
	always_comb
	begin
		case (s2_op)
			l2_cache_pkg::L2REQ_LOAD: response_op = l2_cache_pkg::L2RSP_LOAD_ACK;
			l2_cache_pkg::L2REQ_LOAD_SYNC: response_op = l2_cache_pkg::L2RSP_LOAD_ACK;
			l2_cache_pkg::L2REQ_STORE: response_op = l2_cache_pkg::L2RSP_STORE_ACK;
			l2_cache_pkg::L2REQ_STORE_SYNC: response_op = l2_cache_pkg::L2RSP_STORE_ACK;
			l2_cache_pkg::L2REQ_FLUSH: response_op = l2_cache_pkg::L2RSP_FLUSH_ACK;
			l2_cache_pkg::L2REQ_INVALIDATE: response_op = l2_cache_pkg::L2RSP_INVALIDATE_ACK;
			default: response_op = l2_cache_pkg::L2RSP_LOAD_ACK;
		endcase
	end

	// Every request gets exactly one response packet
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rsp_valid <= 1'b0;
			rsp_status <= 1'b0;
			rsp_core <= '0;
			rsp_unit <= '0;
			rsp_strand <= '0;
			rsp_op <= l2_cache_pkg::L2RSP_LOAD_ACK;
			rsp_way <= '0;
			rsp_data <= '0;
		end
		else if (s2_valid)
		begin
			rsp_valid <= 1'b1;
			// Only a store-sync can report success
			rsp_status <= s2_sync_success;
			rsp_core <= s2_core;
			rsp_unit <= s2_unit;
			rsp_strand <= s2_strand;
			rsp_op <= response_op;
			rsp_way <= s2_way;
			rsp_data <= s2_data;
		end
		else
			rsp_valid <= 1'b0;
	end

endmodule

// ==== hdl/l2_cache.sv ====
// L2 cache top level
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache(
	input clk,
	input reset,
	input req_valid,
	output logic req_ready,
	input [`L2_CORE_BITS-1:0] req_core,
	input [`L2_UNIT_BITS-1:0] req_unit,
	input [`L2_STRAND_BITS-1:0] req_strand,
	input l2_cache_pkg::l2req_op_t req_op,
	input [`L2_ADDR_BITS-1:0] req_address,
	input [`L2_LINE_BITS-1:0] req_data,
	output logic rsp_valid,
	output logic rsp_status,
	output logic [`L2_CORE_BITS-1:0] rsp_core,
	output logic [`L2_UNIT_BITS-1:0] rsp_unit,
	output logic [`L2_STRAND_BITS-1:0] rsp_strand,
	output l2_cache_pkg::l2rsp_op_t rsp_op,
	output logic [`L2_WAY_BITS-1:0] rsp_way,
	output logic [`L2_LINE_BITS-1:0] rsp_data);

	// Stage 1 request
	logic s1_valid;
	logic [`L2_CORE_BITS-1:0] s1_core;
	logic [`L2_UNIT_BITS-1:0] s1_unit;
	logic [`L2_STRAND_BITS-1:0] s1_strand;
	l2_cache_pkg::l2req_op_t s1_op;
	logic [`L2_SET_BITS-1:0] s1_set;
	logic [`L2_TAG_BITS-1:0] s1_tag;
	logic [`L2_LINE_BITS-1:0] s1_data;

	// Way lookup results
	logic [`L2_NUM_WAYS-1:0] way_hit;
	logic [`L2_NUM_WAYS-1:0] way_valid;
	logic [`L2_NUM_WAYS-1:0] way_dirty;
	logic [`L2_NUM_WAYS-1:0][`L2_TAG_BITS-1:0] way_tag;
	logic [`L2_NUM_WAYS-1:0][`L2_LINE_BITS-1:0] way_data;

	// Way write port
	logic [`L2_NUM_WAYS-1:0] way_write_en;
	logic [`L2_SET_BITS-1:0] way_write_set;
	logic [`L2_TAG_BITS-1:0] way_write_tag;
	logic [`L2_LINE_BITS-1:0] way_write_data;
	logic way_write_valid;
	logic way_write_dirty;

	// Backing memory ports
	logic [`L2_LINE_BITS-1:0] mem_read_data;
	logic mem_write_en;
	logic [`L2_ADDR_BITS-1:0] mem_write_address;
	logic [`L2_LINE_BITS-1:0] mem_write_data;

	// Stage 2 result
	logic s2_valid;
	logic [`L2_CORE_BITS-1:0] s2_core;
	logic [`L2_UNIT_BITS-1:0] s2_unit;
	logic [`L2_STRAND_BITS-1:0] s2_strand;
	l2_cache_pkg::l2req_op_t s2_op;
	logic [`L2_WAY_BITS-1:0] s2_way;
	logic [`L2_LINE_BITS-1:0] s2_data;
	logic s2_sync_success;

	l2_cache_tag tag_stage(
		.clk, .reset, .req_valid, .req_core, .req_unit, .req_strand, .req_op,
		.req_address, .req_data, .req_ready, .s1_valid, .s1_core, .s1_unit,
		.s1_strand, .s1_op, .s1_set, .s1_tag, .s1_data);

	// Identical way banks, all looked up in parallel
	genvar w;
	generate
		for (w = 0; w < `L2_NUM_WAYS; w++)
		begin : gen_way
			l2_cache_way way_bank(
				.clk, .reset,
				.lookup_set(s1_set),
				.lookup_tag(s1_tag),
				.write_en(way_write_en[w]),
				.write_set(way_write_set),
				.write_tag(way_write_tag),
				.write_data(way_write_data),
				.write_valid(way_write_valid),
				.write_dirty(way_write_dirty),
				.hit(way_hit[w]),
				.line_valid(way_valid[w]),
				.line_dirty(way_dirty[w]),
				.line_tag(way_tag[w]),
				.line_data(way_data[w]));
		end
	endgenerate

	// Read addressed by the incoming request so data lines up with stage 1
	l2_system_memory system_memory(
		.clk,
		.read_address(req_address),
		.write_en(mem_write_en),
		.write_address(mem_write_address),
		.write_data(mem_write_data),
		.read_data(mem_read_data));

	l2_cache_read read_stage(
		.clk, .reset, .s1_valid, .s1_core, .s1_unit, .s1_strand, .s1_op, .s1_set,
		.s1_tag, .s1_data, .way_hit, .way_valid, .way_dirty, .way_tag, .way_data,
		.mem_read_data, .way_write_en, .way_write_set, .way_write_tag,
		.way_write_data, .way_write_valid, .way_write_dirty, .mem_write_en,
		.mem_write_address, .mem_write_data, .s2_valid, .s2_core, .s2_unit,
		.s2_strand, .s2_op, .s2_way, .s2_data, .s2_sync_success);

	l2_cache_response response_stage(
		.clk, .reset, .s2_valid, .s2_core, .s2_unit, .s2_strand, .s2_op, .s2_way,
		.s2_data, .s2_sync_success, .rsp_valid, .rsp_status, .rsp_core, .rsp_unit,
		.rsp_strand, .rsp_op, .rsp_way, .rsp_data);

endmodule

// ==== testbench/l2_clock_gen.sv ====
// L2 testbench clock and reset
`timescale 1ns/10ps

module l2_clock_gen(
	output logic clk,
	output logic reset);

	localparam PERIOD = 4;
	localparam RESET_CYCLES = 5;

	// Free running clock
	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Reset from time zero, released on a rising edge
	initial
	begin
		reset <= 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== testbench/l2_cache_properties.sv ====
// L2 cache assertions
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_properties(
	input clk,
	input reset,
	input req_valid,
	input req_ready,
	input [`L2_ADDR_BITS-1:0] req_address,
	input rsp_valid,
	input s1_valid,
	input [`L2_NUM_WAYS-1:0] way_hit);

	// Running count of failed assertions
	int unsigned failure_count = 0;

	logic accept;

	assign accept = req_valid && req_ready;

	// A line lives in one way of its set at most
	one_way_hit: assert property (@(posedge clk) disable iff (reset)
		s1_valid |-> $onehot0(way_hit))
	else
	begin
		failure_count = failure_count + 1;
		$error("More than one way hit on the same lookup");
	end

	// Response goes high after the second edge past acceptance,
	// so it is sampled three edges on
	accept_gives_response: assert property (@(posedge clk) disable iff (reset)
		accept |-> ##3 rsp_valid)
	else
	begin
		failure_count = failure_count + 1;
		$error("Accepted request got no response two cycles later");
	end

	// No response without a matching acceptance
	response_needs_accept: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |-> $past(accept, 3))
	else
	begin
		failure_count = failure_count + 1;
		$error("Response without a request accepted two cycles before");
	end

	// Back to back acceptances never share a set
	no_set_conflict: assert property (@(posedge clk) disable iff (reset)
		accept && $past(accept) |-> req_address[`L2_SET_BITS-1:0]
			!= $past(req_address[`L2_SET_BITS-1:0]))
	else
	begin
		failure_count = failure_count + 1;
		$error("Two requests to the same set accepted back to back");
	end

	// Output stage stays quiet in reset
	quiet_in_reset: assert property (@(posedge clk) reset |-> !rsp_valid)
	else
	begin
		failure_count = failure_count + 1;
		$error("Response valid during reset");
	end

endmodule

bind l2_cache l2_cache_properties cache_properties(
	.clk, .reset, .req_valid, .req_ready, .req_address, .rsp_valid,
	.s1_valid, .way_hit);

// ==== testbench/l2_cache_tb.sv ====
// L2 cache testbench
`timescale 1ns/10ps
`include "l2_cache_settings.svh"

module l2_cache_tb;

	localparam NUM_REQUESTS = 2000;
	localparam CLK_PERIOD = 4;
	localparam NUM_RES = 1 << (`L2_CORE_BITS + `L2_STRAND_BITS);
	localparam MEM_LINES = 1 << `L2_ADDR_BITS;

	// One predicted response
	typedef struct packed
	{
		l2_cache_pkg::l2rsp_op_t op;
		logic status;
		logic [`L2_CORE_BITS-1:0] core;
		logic [`L2_UNIT_BITS-1:0] unit;
		logic [`L2_STRAND_BITS-1:0] strand;
		logic [`L2_WAY_BITS-1:0] way;
		logic [`L2_LINE_BITS-1:0] data;
		logic [31:0] due_cycle;
	} expected_t;

	logic clk;
	logic reset;
	logic req_valid;
	logic req_ready;
	logic [`L2_CORE_BITS-1:0] req_core;
	logic [`L2_UNIT_BITS-1:0] req_unit;
	logic [`L2_STRAND_BITS-1:0] req_strand;
	l2_cache_pkg::l2req_op_t req_op;
	logic [`L2_ADDR_BITS-1:0] req_address;
	logic [`L2_LINE_BITS-1:0] req_data;
	logic rsp_valid;
	logic rsp_status;
	logic [`L2_CORE_BITS-1:0] rsp_core;
	logic [`L2_UNIT_BITS-1:0] rsp_unit;
	logic [`L2_STRAND_BITS-1:0] rsp_strand;
	l2_cache_pkg::l2rsp_op_t rsp_op;
	logic [`L2_WAY_BITS-1:0] rsp_way;
	logic [`L2_LINE_BITS-1:0] rsp_data;

	// Reference model, a flat line memory plus reservations
	logic [`L2_LINE_BITS-1:0] model_mem [MEM_LINES];
	logic [NUM_RES-1:0] model_res_valid;
	logic [`L2_ADDR_BITS-1:0] model_res_address [NUM_RES];
	expected_t expected_q[$];

	// Way occupancy per set, for the way each response names
	logic [`L2_NUM_WAYS-1:0] model_way_valid [`L2_NUM_SETS];
	logic [`L2_TAG_BITS-1:0] model_way_tag [`L2_NUM_SETS][`L2_NUM_WAYS];
	logic [`L2_WAY_BITS-1:0] model_rr [`L2_NUM_SETS];

	// Stimulus bookkeeping
	logic [`L2_ADDR_BITS-1:0] last_sync_address [NUM_RES];
	logic [`L2_SET_BITS-1:0] last_set;
	logic [31:0] cycle;
	logic accept_seen;
	int issued;
	int stall_cycles;
	int sync_successes;

	l2_clock_gen clock_gen(.clk, .reset);

	l2_cache dut(.*);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		fail_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
	endtask

	task automatic check_op(input l2_cache_pkg::l2rsp_op_t actual,
		input l2_cache_pkg::l2rsp_op_t expected);
		if (actual !== expected)
			report_mismatch($sformatf("response op %s, expected %s",
				actual.name(), expected.name()));
	endtask

	task automatic check_data(input logic [`L2_LINE_BITS-1:0] actual,
		input logic [`L2_LINE_BITS-1:0] expected);
		if (actual !== expected)
			report_mismatch($sformatf("response data %h, expected %h", actual, expected));
	endtask

	task automatic check_status(input logic actual, input logic expected);
		if (actual !== expected)
			report_mismatch($sformatf("response status %b, expected %b", actual, expected));
	endtask

	task automatic check_way(input logic [`L2_WAY_BITS-1:0] actual,
		input logic [`L2_WAY_BITS-1:0] expected);
		if (actual !== expected)
			report_mismatch($sformatf("response way %0d, expected %0d", actual, expected));
	endtask

	task automatic check_tag_fields(input logic [`L2_CORE_BITS-1:0] core,
		input logic [`L2_UNIT_BITS-1:0] unit,
		input logic [`L2_STRAND_BITS-1:0] strand,
		input expected_t expected);
		if (core !== expected.core || unit !== expected.unit || strand !== expected.strand)
			report_mismatch($sformatf("core/unit/strand %0d/%0d/%0d, expected %0d/%0d/%0d",
				core, unit, strand, expected.core, expected.unit, expected.strand));
	endtask

	// Successful store replaces the line and kills all reservations on it
	task automatic store_line(input logic [`L2_ADDR_BITS-1:0] address,
		input logic [`L2_LINE_BITS-1:0] data);
		model_mem[address] = data;
		for (int i = 0; i < NUM_RES; i++)
		begin
			if (model_res_address[i] == address)
				model_res_valid[i] = 1'b0;
		end
	endtask

	// Way a request lands in, with the tag state and replacement pointer moved on
	task automatic track_way(input logic [`L2_ADDR_BITS-1:0] address,
		input l2_cache_pkg::l2req_op_t op, output logic [`L2_WAY_BITS-1:0] way);
		logic [`L2_SET_BITS-1:0] set;
		logic [`L2_TAG_BITS-1:0] tag;
		logic hit;
		logic free;

		set = address[`L2_SET_BITS-1:0];
		tag = address[`L2_ADDR_BITS-1:`L2_SET_BITS];
		hit = 1'b0;
		free = 1'b0;
		way = model_rr[set];
		for (int i = 0; i < `L2_NUM_WAYS; i++)
		begin
			if (!hit && model_way_valid[set][i] && model_way_tag[set][i] == tag)
			begin
				hit = 1'b1;
				way = i[`L2_WAY_BITS-1:0];
			end
		end
		// A miss takes the first empty way before the round robin victim
		for (int i = 0; i < `L2_NUM_WAYS; i++)
		begin
			if (!hit && !free && !model_way_valid[set][i])
			begin
				free = 1'b1;
				way = i[`L2_WAY_BITS-1:0];
			end
		end
		if (op == l2_cache_pkg::L2REQ_INVALIDATE)
		begin
			if (hit)
				model_way_valid[set][way] = 1'b0;
		end
		else if (op != l2_cache_pkg::L2REQ_FLUSH && !hit)
		begin
			// Loads and stores allocate, and each fill steps the pointer
			model_way_valid[set][way] = 1'b1;
			model_way_tag[set][way] = tag;
			model_rr[set] = model_rr[set] + 1'b1;
		end
	endtask

	// Apply the accepted request to the model and queue its response
	task automatic predict_response();
		expected_t expected;
		logic [`L2_CORE_BITS+`L2_STRAND_BITS-1:0] res_index;
		logic [`L2_WAY_BITS-1:0] way;

		res_index = {req_core, req_strand};
		track_way(req_address, req_op, way);
		expected.op = l2_cache_pkg::L2RSP_LOAD_ACK;
		expected.status = 1'b0;
		expected.core = req_core;
		expected.unit = req_unit;
		expected.strand = req_strand;
		expected.way = way;
		expected.data = model_mem[req_address];
		expected.due_cycle = cycle + 3;
		case (req_op)
			l2_cache_pkg::L2REQ_LOAD_SYNC:
			begin
				model_res_valid[res_index] = 1'b1;
				model_res_address[res_index] = req_address;
			end
			l2_cache_pkg::L2REQ_STORE:
			begin
				expected.op = l2_cache_pkg::L2RSP_STORE_ACK;
				expected.data = req_data;
				store_line(req_address, req_data);
			end
			l2_cache_pkg::L2REQ_STORE_SYNC:
			begin
				expected.op = l2_cache_pkg::L2RSP_STORE_ACK;
				// Failed store-sync leaves memory alone and returns the old line
				if (model_res_valid[res_index] && model_res_address[res_index] == req_address)
				begin
					expected.status = 1'b1;
					expected.data = req_data;
					sync_successes++;
					store_line(req_address, req_data);
				end
			end
			l2_cache_pkg::L2REQ_FLUSH:
				expected.op = l2_cache_pkg::L2RSP_FLUSH_ACK;
			l2_cache_pkg::L2REQ_INVALIDATE:
				expected.op = l2_cache_pkg::L2RSP_INVALIDATE_ACK;
			default:
				expected.op = l2_cache_pkg::L2RSP_LOAD_ACK;
		endcase
		expected_q.push_back(expected);
	endtask

	task automatic drive_random_request();
		logic [31:0] word;
		logic [31:0] pick;
		logic [`L2_CORE_BITS-1:0] core;
		logic [`L2_STRAND_BITS-1:0] strand;
		logic [`L2_SET_BITS-1:0] set;
		logic [`L2_TAG_BITS-1:0] tag;
		logic [`L2_ADDR_BITS-1:0] address;
		l2_cache_pkg::l2req_op_t op;

		word = $urandom;
		core = word[`L2_CORE_BITS-1:0];
		strand = word[8+`L2_STRAND_BITS-1:8];
		req_unit <= word[16+`L2_UNIT_BITS-1:16];
		// Revisit the last set now and then to hit the stall
		pick = $urandom_range(0, 3);
		set = pick == 0 ? last_set : word[24+`L2_SET_BITS-1:24];
		// Six tags per set overflow four ways
		pick = $urandom_range(0, 5);
		tag = pick[`L2_TAG_BITS-1:0];
		address = {tag, set};

		pick = $urandom_range(0, 99);
		if (pick < 35)
			op = l2_cache_pkg::L2REQ_LOAD;
		else if (pick < 60)
			op = l2_cache_pkg::L2REQ_STORE;
		else if (pick < 68)
			op = l2_cache_pkg::L2REQ_FLUSH;
		else if (pick < 75)
			op = l2_cache_pkg::L2REQ_INVALIDATE;
		else if (pick < 87)
			op = l2_cache_pkg::L2REQ_LOAD_SYNC;
		else
			op = l2_cache_pkg::L2REQ_STORE_SYNC;

		// Mostly pair a store-sync with its own earlier load-sync
		pick = $urandom_range(0, 3);
		if (op == l2_cache_pkg::L2REQ_STORE_SYNC && pick != 0)
			address = last_sync_address[{core, strand}];
		if (op == l2_cache_pkg::L2REQ_LOAD_SYNC)
			last_sync_address[{core, strand}] = address;
		last_set = address[`L2_SET_BITS-1:0];

		req_valid <= 1'b1;
		req_core <= core;
		req_strand <= strand;
		req_op <= op;
		req_address <= address;
		req_data <= {$urandom, $urandom, $urandom, $urandom};
	endtask

	// Sample on the falling edge, away from the DUT's rising edge updates
	always @(negedge clk)
	begin : monitor
		expected_t expected;

		if (!reset)
		begin
			cycle = cycle + 1;
			if (dut.cache_properties.failure_count != 0)
				fail_run("A bound assertion on the cache failed");
			if (rsp_valid === 1'b1)
			begin
				if (expected_q.size() == 0)
					fail_run("A response arrived with no request outstanding");
				else
				begin
					expected = expected_q.pop_front();
					if (expected.due_cycle != cycle)
						report_mismatch($sformatf("response in cycle %0d, expected in %0d",
							cycle, expected.due_cycle));
					check_op(rsp_op, expected.op);
					check_status(rsp_status, expected.status);
					check_tag_fields(rsp_core, rsp_unit, rsp_strand, expected);
					check_way(rsp_way, expected.way);
					check_data(rsp_data, expected.data);
				end
			end
			else if (expected_q.size() != 0 && expected_q[0].due_cycle <= cycle)
				fail_run("An expected response did not arrive in time");

			// Request seen here is taken on the next rising edge
			accept_seen = req_valid && req_ready;
			if (accept_seen)
				predict_response();
			else if (req_valid)
				stall_cycles++;
		end
	end

	initial
	begin : stimulus
		logic [31:0] gap;

		void'($urandom(32'hf7e5));
		req_valid = 1'b0;
		req_core = '0;
		req_unit = '0;
		req_strand = '0;
		req_op = l2_cache_pkg::L2REQ_LOAD;
		req_address = '0;
		req_data = '0;
		cycle = '0;
		accept_seen = 1'b0;
		last_set = '0;
		issued = 0;
		stall_cycles = 0;
		sync_successes = 0;
		model_res_valid = '0;
		for (int i = 0; i < MEM_LINES; i++)
			model_mem[i] = '0;
		for (int i = 0; i < NUM_RES; i++)
		begin
			model_res_address[i] = '0;
			last_sync_address[i] = '0;
		end
		for (int i = 0; i < `L2_NUM_SETS; i++)
		begin
			model_way_valid[i] = '0;
			model_rr[i] = '0;
		end

		@(negedge reset);
		while (issued < NUM_REQUESTS || req_valid)
		begin
			@(posedge clk);
			// Hold a request until it is taken, then maybe idle a cycle
			if (!req_valid || accept_seen)
			begin
				gap = $urandom_range(0, 3);
				if (issued < NUM_REQUESTS && gap != 0)
				begin
					drive_random_request();
					issued++;
				end
				else
					req_valid <= 1'b0;
			end
		end

		// Drain the pipeline and watch for stray responses
		while (expected_q.size() != 0)
			@(posedge clk);
		repeat (4)
			@(posedge clk);

		if (stall_cycles == 0)
			fail_run("No same-set stall was exercised");
		else if (sync_successes == 0)
			fail_run("No store-sync ever succeeded");
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

	// Generous bound of ten cycles per request
	initial
	begin : watchdog
		#(NUM_REQUESTS * 10 * CLK_PERIOD);
		fail_run("Timeout: the run did not finish within its time limit");
	end

endmodule

// ==== flist.f ====
+incdir+include
hdl/l2_cache_pkg.sv
hdl/l2_cache_tag.sv
hdl/l2_cache_way.sv
hdl/l2_cache_read.sv
hdl/l2_system_memory.sv
hdl/l2_cache_response.sv
hdl/l2_cache.sv
testbench/l2_clock_gen.sv
testbench/l2_cache_properties.sv
testbench/l2_cache_tb.sv
